// ==== src.f ====
design/hbm_mgmt_pkg.sv
design/hbm_mgmt_decoder.sv
design/hbm_mgmt_regs.sv
design/hbm_channel_apb_fwd.sv
design/hbm_mgmt_top.sv
bench/hbm_mgmt_checker.sv
bench/tb_hbm_mgmt.sv

// ==== Bender.yml ====
package:
  name: hbm_mgmt

sources:
  - design/hbm_mgmt_pkg.sv
  - design/hbm_mgmt_decoder.sv
  - design/hbm_mgmt_regs.sv
  - design/hbm_channel_apb_fwd.sv
  - design/hbm_mgmt_top.sv
  - target: test
    files:
      - bench/hbm_mgmt_checker.sv
      - bench/tb_hbm_mgmt.sv

// ==== bench/tb_hbm_mgmt.sv ====
// ----------------------------------------
// Testbench for the HBM management top level.
// Clock, reset, HBM APB completer model with
// LFSR wait states, and a stimulus table run in
// a loop. Checking lives in hbm_mgmt_checker.
// ----------------------------------------
`timescale 1ns/1ps

module tb_hbm_mgmt
    import hbm_mgmt_pkg::*;
();

    localparam logic [1:0] OP_WR = 2'd0;
    localparam logic [1:0] OP_RD = 2'd1;
    // Set status inputs and probe mem_rst
    localparam logic [1:0] OP_ST = 2'd2;

    // Row: status data is {init_done, cattrip, temp[6:0]} in bits 8:0
    typedef struct packed {
        logic [1:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] exp;
        logic        err;
    } row_t;

    logic        clk;
    logic        rst;
    apb_req_t    host_req;
    apb_rsp_t    host_rsp;
    apb_req_t    mem_req;
    apb_rsp_t    mem_rsp;
    logic        init_done;
    logic        dram_cattrip;
    logic [6:0]  dram_temp;
    logic        mem_rst;
    logic        probe;
    logic [31:0] exp_data;
    logic        exp_err;
    int          n_tests;
    int          n_failed;
    row_t        table_q[$];
    int          cycles = 0;
    int          limit = 1000;

    // HBM completer model state
    logic [31:0] lfsr = 32'h622da8e2;
    logic        active = 1'b0;
    logic [1:0]  wait_left = 2'd0;
    logic [31:0] lat_addr = 32'd0;

    hbm_mgmt_top #(
        .CHAN_OFFSET_W (17)
    ) i_hbm_mgmt_top (
        .clk          (clk),
        .rst          (rst),
        .host_req     (host_req),
        .host_rsp     (host_rsp),
        .mem_req      (mem_req),
        .mem_rsp      (mem_rsp),
        .init_done    (init_done),
        .dram_cattrip (dram_cattrip),
        .dram_temp    (dram_temp),
        .mem_rst      (mem_rst)
    );

    hbm_mgmt_checker i_hbm_mgmt_checker (
        .clk      (clk),
        .rst      (rst),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp),
        .mem_rst  (mem_rst),
        .probe    (probe),
        .exp_data (exp_data),
        .exp_err  (exp_err),
        .n_tests  (n_tests),
        .n_failed (n_failed)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Galois LFSR, one step per random bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hA300_0000;
        end else begin
            return s >> 1;
        end
    endfunction

    // ----------------------------------------
    // HBM APB completer, 0 to 3 wait states
    // ----------------------------------------
    always @(posedge clk) begin
        logic [1:0] w;
        if (rst) begin
            active    <= 1'b0;
            wait_left <= 2'd0;
        end else if (mem_req.sel && !mem_req.enable) begin
            lfsr = lfsr_step(lfsr);
            w[0] = lfsr[0];
            lfsr = lfsr_step(lfsr);
            w[1] = lfsr[0];
            active    <= 1'b1;
            wait_left <= w;
            lat_addr  <= mem_req.addr;
        end else if (mem_req.sel && mem_req.enable) begin
            if (mem_rsp.ready) begin
                active <= 1'b0;
            end else begin
                wait_left <= wait_left - 2'd1;
            end
        end
    end

    // Response moves on the falling edge
    always @(negedge clk) begin
        mem_rsp.ready  = active && (wait_left == 2'd0);
        mem_rsp.rdata  = 32'hA500_0000 | {10'b0, lat_addr[21:0]};
        mem_rsp.slverr = 1'b0;
    end

    // Run limit from the table length
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout after %0d cycles, a transfer never completed", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic add_row(input logic [1:0] op, input logic [31:0] addr,
                           input logic [31:0] data, input logic [31:0] exp,
                           input logic err);
        table_q.push_back('{op, addr, data, exp, err});
    endtask

    // ----------------------------------------
    // Stimulus table
    // ----------------------------------------
    task automatic build_table();
        // Reset values
        add_row(OP_RD, 32'h0000_0000, 32'h0, 32'h0000_0000, 1'b0);
        add_row(OP_RD, 32'h0000_000C, 32'h0, 32'h0000_0000, 1'b0);
        add_row(OP_RD, 32'h0000_0004, 32'h0, 32'h0000_0000, 1'b0);
        // Init done, then block reset on and off
        add_row(OP_ST, 32'h0,         32'h100, 32'h0000_0000, 1'b0);
        add_row(OP_RD, 32'h0000_0004, 32'h0, 32'h0000_0002, 1'b0);
        add_row(OP_WR, 32'h0000_0000, 32'h1, 32'h0000_0000, 1'b0);
        add_row(OP_RD, 32'h0000_0000, 32'h0, 32'h0000_0001, 1'b0);
        add_row(OP_ST, 32'h0,         32'h100, 32'h0000_0001, 1'b0);
        add_row(OP_RD, 32'h0000_0004, 32'h0, 32'h0000_0003, 1'b0);
        add_row(OP_WR, 32'h0000_0000, 32'h0, 32'h0000_0000, 1'b0);
        // Cattrip with temp 0x55
        add_row(OP_ST, 32'h0,         32'h1D5, 32'h0000_0000, 1'b0);
        add_row(OP_RD, 32'h0000_0004, 32'h0, 32'h0000_0002, 1'b0);
        add_row(OP_RD, 32'h0000_0008, 32'h0, 32'h0000_00D5, 1'b0);
        add_row(OP_ST, 32'h0,         32'h02A, 32'h0000_0000, 1'b0);
        add_row(OP_RD, 32'h0000_0008, 32'h0, 32'h0000_002A, 1'b0);
        add_row(OP_RD, 32'h0000_0004, 32'h0, 32'h0000_0000, 1'b0);
        add_row(OP_WR, 32'h0000_000C, 32'h6, 32'h0000_0000, 1'b0);
        // Bits outside index and window are ignored
        add_row(OP_RD, 32'hFE0F_FF0C, 32'h0, 32'h0000_0006, 1'b0);
        // Undefined indices 4 and 15
        add_row(OP_WR, 32'h0000_0010, 32'h7, 32'h0000_0000, 1'b1);
        add_row(OP_RD, 32'h0000_003C, 32'h0, 32'h0000_0000, 1'b1);
        add_row(OP_RD, 32'h0000_000C, 32'h0, 32'h0000_0006, 1'b0);
        add_row(OP_RD, 32'h0000_0000, 32'h0, 32'h0000_0000, 1'b0);
        // Channels 0 to 7, exp is A5 tag over {select code, offset}
        add_row(OP_WR, 32'h0000_000C, 32'h0, 32'h0000_0000, 1'b0);
        add_row(OP_RD, 32'hFFF0_0000, 32'h0, 32'hA510_0000, 1'b0);
        add_row(OP_WR, 32'h0000_000C, 32'h1, 32'h0000_0000, 1'b0);
        add_row(OP_RD, 32'h0011_FFFF, 32'h0, 32'hA519_FFFF, 1'b0);
        add_row(OP_WR, 32'h0000_000C, 32'h2, 32'h0000_0000, 1'b0);
        add_row(OP_RD, 32'h0010_ABCD, 32'h0, 32'hA512_ABCD, 1'b0);
        add_row(OP_WR, 32'h0000_000C, 32'h3, 32'h0000_0000, 1'b0);
        add_row(OP_RD, 32'h0011_2345, 32'h0, 32'hA51B_2345, 1'b0);
        add_row(OP_WR, 32'h0000_000C, 32'h4, 32'h0000_0000, 1'b0);
        add_row(OP_RD, 32'h0010_0F0F, 32'h0, 32'hA514_0F0F, 1'b0);
        add_row(OP_WR, 32'h0000_000C, 32'h5, 32'h0000_0000, 1'b0);
        add_row(OP_RD, 32'h0011_5555, 32'h0, 32'hA51D_5555, 1'b0);
        add_row(OP_WR, 32'h0000_000C, 32'h6, 32'h0000_0000, 1'b0);
        add_row(OP_RD, 32'h0010_A5A5, 32'h0, 32'hA516_A5A5, 1'b0);
        add_row(OP_WR, 32'h0000_000C, 32'h7, 32'h0000_0000, 1'b0);
        add_row(OP_RD, 32'h001F_C3C3, 32'h0, 32'hA51F_C3C3, 1'b0);
        // Channel write, data carried downstream
        add_row(OP_WR, 32'h0010_1234, 32'h3C5A_9617, 32'hA51E_1234, 1'b0);
    endtask

    // One row, entered and left on a falling edge, two idle cycles after
    task automatic apply_row(input row_t r);
        exp_data = r.exp;
        exp_err  = r.err;
        if (r.op == OP_ST) begin
            init_done    = r.data[8];
            dram_cattrip = r.data[7];
            dram_temp    = r.data[6:0];
            probe        = 1'b1;
            @(negedge clk);
            probe        = 1'b0;
        end else begin
            // Setup cycle
            host_req.sel    = 1'b1;
            host_req.enable = 1'b0;
            host_req.write  = (r.op == OP_WR);
            host_req.addr   = r.addr;
            host_req.wdata  = r.data;
            host_req.strb   = 4'hF;
            @(negedge clk);
            host_req.enable = 1'b1;
            // Access cycles until ready
            do begin
                @(posedge clk);
            end while (!host_rsp.ready);
            @(negedge clk);
            host_req = '0;
        end
        repeat (2) @(negedge clk);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        rst          = 1'b1;
        host_req     = '0;
        mem_rsp      = '0;
        init_done    = 1'b0;
        dram_cattrip = 1'b0;
        dram_temp    = 7'd0;
        probe        = 1'b0;
        exp_data     = 32'd0;
        exp_err      = 1'b0;
        build_table();
        limit = table_q.size() * 8 + 50;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // mem_rst and status reset bit settle
        repeat (2) @(negedge clk);
        foreach (table_q[i]) begin
            apply_row(table_q[i]);
        end
        $display("Tests run: %0d, failed: %0d", n_tests, n_failed);
        if (n_failed == 0 && n_tests == table_q.size()) begin
            $display("Simulation finished: PASS");
        end else begin
            if (n_tests != table_q.size()) begin
                $display("Only %0d of %0d tests were checked", n_tests, table_q.size());
            end
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule : tb_hbm_mgmt

// ==== bench/hbm_mgmt_checker.sv ====
// ----------------------------------------
// Result checker for the management testbench.
// Watches host and HBM APB ports, compares each
// completed transfer or status probe with the
// expected values of the current table row and
// prints one line per test.
// ----------------------------------------
`timescale 1ns/1ps

module hbm_mgmt_checker
    import hbm_mgmt_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  apb_req_t    host_req,
    input  apb_rsp_t    host_rsp,
    input  apb_req_t    mem_req,
    input  apb_rsp_t    mem_rsp,
    input  logic        mem_rst,
    // Status probe strobe and current row expectations
    input  logic        probe,
    input  logic [31:0] exp_data,
    input  logic        exp_err,
    output int          n_tests,
    output int          n_failed
);

    logic test_bad;
    logic host_done;
    logic mem_done;

    // Access cycles that end on this edge
    assign host_done = host_req.sel && host_req.enable && host_rsp.ready;
    assign mem_done  = mem_req.sel && mem_req.enable && mem_rsp.ready;

    initial begin
        n_tests  = 0;
        n_failed = 0;
        test_bad = 1'b0;
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("Error at %0t: %s = %h, expected %h", $time, name, got, want);
            test_bad = 1'b1;
        end
    endtask

    task automatic close_test();
        $display("Test %0d %s", n_tests, test_bad ? "failed" : "passed");
        n_tests = n_tests + 1;
        if (test_bad) begin
            n_failed = n_failed + 1;
        end
    endtask

    // ----------------------------------------
    // Comparison at the completing edge
    // ----------------------------------------
    always @(posedge clk) begin
        if (!rst && host_done) begin
            test_bad = 1'b0;
            compare("host_rsp.slverr", 32'(host_rsp.slverr), 32'(exp_err));
            if (!host_req.write) begin
                compare("host_rsp.rdata", host_rsp.rdata, exp_data);
            end
            // Window bit 20 set, downstream must complete on the same edge
            if (host_req.addr[20]) begin
                if (!mem_done) begin
                    $display("Channel transfer at %0t ended without a downstream access",
                             $time);
                    test_bad = 1'b1;
                end else begin
                    // Model tags low 22 address bits, so expected address sits in exp
                    compare("mem_req.addr", mem_req.addr, {10'b0, exp_data[21:0]});
                    // Direction and write data pass through untouched
                    compare("mem_req.write", 32'(mem_req.write), 32'(host_req.write));
                    compare("mem_req.wdata", mem_req.wdata, host_req.wdata);
                end
            end else if (mem_req.sel) begin
                $display("Local transfer at %0t reached the downstream port", $time);
                test_bad = 1'b1;
            end
            close_test();
        end
        if (!rst && probe) begin
            test_bad = 1'b0;
            compare("mem_rst", 32'(mem_rst), 32'(exp_data[0]));
            close_test();
        end
    end

endmodule : hbm_mgmt_checker

// ==== design/hbm_mgmt_top.sv ====
// ----------------------------------------
// Top level of the HBM management subsystem.
// Host APB in, HBM management APB out, plus
// status inputs and the block reset output.
// Wires the decoder, registers and forwarder.
// ----------------------------------------
`timescale 1ns/1ps

module hbm_mgmt_top
    import hbm_mgmt_pkg::*;
#(
    parameter int CHAN_OFFSET_W = hbm_mgmt_pkg::CHAN_OFFSET_W
)(
    input  logic       clk,
    input  logic       rst,

    // Host APB completer
    input  apb_req_t   host_req,
    output apb_rsp_t   host_rsp,

    // HBM management APB requester
    output apb_req_t   mem_req,
    input  apb_rsp_t   mem_rsp,

    // Memory block status
    input  logic       init_done,
    input  logic       dram_cattrip,
    input  logic [6:0] dram_temp,

    // Block-level reset
    output logic       mem_rst
);

    // ----------------------------------------
    // Internal buses
    // ----------------------------------------
    apb_req_t   reg_req;
    apb_rsp_t   reg_rsp;
    apb_req_t   chan_req;
    apb_rsp_t   chan_rsp;
    logic [2:0] chan_sel;

    // Window split
    hbm_mgmt_decoder i_hbm_mgmt_decoder (
        .clk      (clk),
        .rst      (rst),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .reg_req  (reg_req),
        .reg_rsp  (reg_rsp),
        .chan_req (chan_req),
        .chan_rsp (chan_rsp)
    );

    // Local registers and block reset
    hbm_mgmt_regs i_hbm_mgmt_regs (
        .clk          (clk),
        .rst          (rst),
        .req          (reg_req),
        .rsp          (reg_rsp),
        .init_done    (init_done),
        .dram_cattrip (dram_cattrip),
        .dram_temp    (dram_temp),
        .mem_rst      (mem_rst),
        .chan_sel     (chan_sel)
    );

    // Channel window to the memory controllers
    hbm_channel_apb_fwd #(
        .CHAN_OFFSET_W (CHAN_OFFSET_W)
    ) i_hbm_channel_apb_fwd (
        .clk      (clk),
        .rst      (rst),
        .chan_sel (chan_sel),
        .req      (chan_req),
        .rsp      (chan_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

endmodule : hbm_mgmt_top

// ==== design/hbm_channel_apb_fwd.sv ====
// ----------------------------------------
// Channel window forwarder. Passes host APB
// transfers to the HBM management port with
// the upper address bits replaced by the
// encoded controller select. The select is
// latched per transfer in the setup cycle.
// ----------------------------------------
`timescale 1ns/1ps

module hbm_channel_apb_fwd
    import hbm_mgmt_pkg::*;
#(
    // Offset bits kept from the host address, at most 17
    parameter int CHAN_OFFSET_W = hbm_mgmt_pkg::CHAN_OFFSET_W
)(
    input  logic       clk,
    input  logic       rst,

    // Controller number from the channel-select register
    input  logic [2:0] chan_sel,

    // From the decoder
    input  apb_req_t   req,
    output apb_rsp_t   rsp,

    // To the memory management port
    output apb_req_t   mem_req,
    input  apb_rsp_t   mem_rsp
);

    localparam int MEM_ADDR_W = CHAN_SEL_W + CHAN_OFFSET_W;

    // ----------------------------------------
    // Signals
    // ----------------------------------------
    host_addr_u              addr;
    logic [16:0]             offset;
    logic                    setup;
    logic [CHAN_SEL_W-1:0]   sel_code_q;
    logic [CHAN_SEL_W-1:0]   sel_code;
    logic [MEM_ADDR_W-1:0]   mem_addr;

    assign addr   = req.addr;
    assign offset = addr.chan_view.offset;
    assign setup  = req.sel & ~req.enable;

    // Capture the code at the end of setup
    always_ff @(posedge clk) begin
        if (setup) begin
            sel_code_q <= chan_sel_enc(chan_sel);
        end
    end

    // Live code in setup, held code through the access cycles
    assign sel_code = setup ? chan_sel_enc(chan_sel) : sel_code_q;
    assign mem_addr = {sel_code, offset[CHAN_OFFSET_W-1:0]};

    // ----------------------------------------
    // Downstream request, response passes back
    // ----------------------------------------
    always_comb begin
        mem_req      = req;
        mem_req.addr = 32'(mem_addr);
    end

    assign rsp = mem_rsp;

    // Address may not move while a downstream wait state is pending
    a_mem_addr_stable : assert property (@(posedge clk) disable iff (rst)
        (mem_req.sel && mem_req.enable && !mem_rsp.ready)
        |=> $stable(mem_req.addr));

endmodule : hbm_channel_apb_fwd

// ==== design/hbm_mgmt_regs.sv ====
// ----------------------------------------
// Local register block of the management
// subsystem. Control, status, DRAM status and
// channel-select registers on an APB
// completer, plus the block-level reset flop
// that drives mem_rst. Zero wait states.
// ----------------------------------------
`timescale 1ns/1ps

module hbm_mgmt_regs
    import hbm_mgmt_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // APB completer
    input  apb_req_t   req,
    output apb_rsp_t   rsp,

    // Status inputs from the memory block
    input  logic       init_done,
    input  logic       dram_cattrip,
    input  logic [6:0] dram_temp,

    // Block control outputs
    output logic       mem_rst,
    output logic [2:0] chan_sel
);

    // Status layout, reset in bit 0, init_done in bit 1
    typedef struct packed {
        logic init_done;
        logic reset;
    } status_t;

    // DRAM status layout, temp in 6:0, cattrip in bit 7
    typedef struct packed {
        logic       cattrip;
        logic [6:0] temp;
    } dram_status_t;

    // ----------------------------------------
    // Signals
    // ----------------------------------------
    host_addr_u   addr;
    logic [3:0]   idx;
    logic         access;
    logic         wr_en;
    logic         idx_bad;

    logic         ctrl_reset_q;
    logic [2:0]   chan_sel_q;
    logic         mem_rst_q;
    status_t      status_q;
    dram_status_t dram_status_q;

    assign addr   = req.addr;
    assign idx    = addr.reg_view.idx;
    // Access cycle, always completes here
    assign access = req.sel & req.enable;
    // Only byte lane 0 carries register bits
    assign wr_en  = access & req.write & req.strb[0];

    // Unknown index
    always_comb begin
        case (idx)
            REG_CONTROL, REG_STATUS, REG_DRAM_STATUS, REG_CHAN_SEL: idx_bad = 1'b0;
            default:                                                idx_bad = 1'b1;
        endcase
    end

    // ----------------------------------------
    // Writable registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_reset_q <= 1'b0;
            chan_sel_q   <= 3'd0;
        end else if (wr_en) begin
            // Status registers are read-only, writes dropped
            if (idx == REG_CONTROL) begin
                ctrl_reset_q <= req.wdata[0];
            end
            if (idx == REG_CHAN_SEL) begin
                chan_sel_q <= req.wdata[2:0];
            end
        end
    end

    // Block reset, one cycle behind rst or control bit 0
    always_ff @(posedge clk) begin
        mem_rst_q <= rst | ctrl_reset_q;
    end

    // Status sampled every clock
    always_ff @(posedge clk) begin
        status_q.reset        <= mem_rst_q;
        status_q.init_done    <= init_done;
        dram_status_q.cattrip <= dram_cattrip;
        dram_status_q.temp    <= dram_temp;
    end

    // ----------------------------------------
    // Read path
    // ----------------------------------------
    always_comb begin
        rsp.ready  = access;
        rsp.slverr = access & idx_bad;
        case (idx)
            REG_CONTROL:     rsp.rdata = {31'b0, ctrl_reset_q};
            REG_STATUS:      rsp.rdata = {30'b0, status_q};
            REG_DRAM_STATUS: rsp.rdata = {24'b0, dram_status_q};
            REG_CHAN_SEL:    rsp.rdata = {29'b0, chan_sel_q};
            default:         rsp.rdata = 32'b0;
        endcase
    end

    assign mem_rst  = mem_rst_q;
    assign chan_sel = chan_sel_q;

endmodule : hbm_mgmt_regs

// ==== design/hbm_mgmt_decoder.sv ====
// ----------------------------------------
// Host APB address decoder. Steers each host
// transfer to the local register block or to
// the channel forwarder on the window bit,
// and returns the selected side's response.
// ----------------------------------------
`timescale 1ns/1ps

module hbm_mgmt_decoder
    import hbm_mgmt_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // Host side
    input  apb_req_t host_req,
    output apb_rsp_t host_rsp,

    // Local register block
    output apb_req_t reg_req,
    input  apb_rsp_t reg_rsp,

    // Channel forwarder
    output apb_req_t chan_req,
    input  apb_rsp_t chan_rsp
);

    // ----------------------------------------
    // Window decode
    // ----------------------------------------
    host_addr_u host_addr;
    logic       chan_win;

    assign host_addr = host_req.addr;
    assign chan_win  = host_addr.chan_view.win;

    // Request fan-out, only the addressed side sees sel and enable
    always_comb begin
        reg_req         = host_req;
        chan_req        = host_req;
        reg_req.sel     = host_req.sel & ~chan_win;
        reg_req.enable  = host_req.enable & ~chan_win;
        chan_req.sel    = host_req.sel & chan_win;
        chan_req.enable = host_req.enable & chan_win;
    end

    // Response merge
    always_comb begin
        if (!host_req.sel) begin
            // Idle bus, nothing to answer
            host_rsp = '0;
        end else if (chan_win) begin
            host_rsp = chan_rsp;
        end else begin
            host_rsp = reg_rsp;
        end
    end

    // ----------------------------------------
    // Assertions
    // ----------------------------------------
    // Host holds the transfer until the access cycle sees ready
    a_host_stable : assert property (@(posedge clk) disable iff (rst)
        (host_req.sel && !(host_req.enable && host_rsp.ready))
        |=> host_req.sel && host_req.enable
            && $stable(host_req.addr) && $stable(host_req.write)
            && $stable(host_req.wdata) && $stable(host_req.strb));

endmodule : hbm_mgmt_decoder

// ==== design/hbm_mgmt_pkg.sv ====
// ----------------------------------------
// Shared types and constants for the HBM
// management subsystem. Holds the APB request
// and response structs, the two-way host
// address view, the local register indices
// and the memory controller select encoding.
// ----------------------------------------
package hbm_mgmt_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    // Encoded controller select prepended downstream
    localparam int CHAN_SEL_W = 5;
    // Default channel offset width
    localparam int CHAN_OFFSET_W = 17;

    // ----------------------------------------
    // APB request and response
    // ----------------------------------------
    typedef struct packed {
        logic        sel;
        logic        enable;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
    } apb_req_t;

    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
        logic        slverr;
    } apb_rsp_t;

    // ----------------------------------------
    // Host address views
    // ----------------------------------------
    // Window bit 0 selects local registers, 1 the channel window
    typedef struct packed {
        logic [10:0] rsvd_hi;
        logic        win;
        logic [13:0] rsvd_mid;
        logic [3:0]  idx;
        logic [1:0]  rsvd_lo;
    } host_reg_view_t;

    typedef struct packed {
        logic [10:0] rsvd_hi;
        logic        win;
        logic [2:0]  rsvd_mid;
        logic [16:0] offset;
    } host_chan_view_t;

    // Same 32 address bits, decoded as register index or channel offset
    typedef union packed {
        host_reg_view_t  reg_view;
        host_chan_view_t chan_view;
    } host_addr_u;

    // ----------------------------------------
    // Local register indices
    // ----------------------------------------
    localparam logic [3:0] REG_CONTROL     = 4'd0;
    localparam logic [3:0] REG_STATUS      = 4'd1;
    localparam logic [3:0] REG_DRAM_STATUS = 4'd2;
    localparam logic [3:0] REG_CHAN_SEL    = 4'd3;

    // Controller number to upper address bits of the HBM APB port
    function automatic logic [CHAN_SEL_W-1:0] chan_sel_enc(input logic [2:0] chan);
        logic [CHAN_SEL_W-1:0] code;
        case (chan)
            3'd0:    code = 5'b01000;
            3'd1:    code = 5'b01100;
            3'd2:    code = 5'b01001;
            3'd3:    code = 5'b01101;
            3'd4:    code = 5'b01010;
            3'd5:    code = 5'b01110;
            3'd6:    code = 5'b01011;
            default: code = 5'b01111;
        endcase
        return code;
    endfunction

endpackage : hbm_mgmt_pkg
